/* hw/ubaPkg.sv */
//////////////////////////////
// Word addresses only; no byte lanes, no page mapping
// Device window is 8 words at devBase, only the low 4 implemented
//////////////////////////////

package ubaPkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////

   // 18-bit word address
   typedef logic [17:0] addrT;
   // 16-bit data word
   typedef logic [15:0] dataT;

   //////////////////////////////
   // Address map
   //////////////////////////////

   // Adapter control/status register
   localparam addrT csrAddr = 18'o763000;
   // Base of the 8-word device window
   localparam addrT devBase = 18'o764000;
   // Implemented registers at offsets 0 to 3
   localparam int devWords = 4;
   localparam int devIdxW  = $clog2(devWords);
   typedef logic [devIdxW-1:0] devIdxT;

   // Device acknowledge latency in cycles
   localparam int devLatency = 2;
   localparam int devCntW    = $clog2(devLatency + 1);
   typedef logic [devCntW-1:0] devCntT;

   // CSR bit position of the sticky NXD flag
   localparam int nxdBit = 0;

   //////////////////////////////
   // Watchdog
   //////////////////////////////

   // Count cycles before a cycle is declared non-existent
   localparam int nxdTimeout = 10;
   localparam int wdCntW     = $clog2(nxdTimeout);
   typedef logic [wdCntW-1:0] wdCntT;

   typedef enum logic [2:0] {wdIdle, wdCount, wdAck, wdNxd, wdWait} wdStateT;

endpackage

/* hw/busMaster.sv */
//////////////////////////////
// Single master, one word per cycle
// cmdStb while busy is high is dropped
//////////////////////////////
`timescale 1ns/1ps

module busMaster
(
   input  logic         clk,
   input  logic         rst,
   // Host command port
   input  logic         cmdStb,
   input  logic         cmdWrite,
   input  ubaPkg::addrT cmdAddr,
   input  ubaPkg::dataT cmdData,
   // Host response port
   output logic         rspStb,
   output ubaPkg::dataT rspData,
   output logic         rspNxd,
   output logic         busy,
   // Bus side
   output logic         busReq,
   output logic         busWrite,
   output ubaPkg::addrT busAddr,
   output ubaPkg::dataT busWData,
   input  logic         busAck,
   input  logic         setNxd,
   input  ubaPkg::dataT busRData
);

   logic accept;
   logic finish;

   // New command only taken with no cycle running
   assign accept = cmdStb && !busReq;
   // Cycle ends on acknowledge or on watchdog timeout
   assign finish = busReq && (busAck || setNxd);

   // Busy window is exactly the request window
   assign busy = busReq;

   //////////////////////////////
   // Request and response control
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busReq <= 1'b0;
         rspStb <= 1'b0;
         rspNxd <= 1'b0;
      end
      else
      begin
         // Response strobe is one cycle wide
         rspStb <= 1'b0;
         if (accept)
         begin
            busReq <= 1'b1;
         end
         else if (finish)
         begin
            busReq <= 1'b0;
            rspStb <= 1'b1;
            rspNxd <= setNxd;
         end
      end
   end

   // Command and read data capture
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         busWrite <= cmdWrite;
         busAddr  <= cmdAddr;
         busWData <= cmdData;
      end
      if (finish)
      begin
         // Timed out cycles return zero data
         rspData <= busAck ? busRData : '0;
      end
   end

   // Watchdog grants and timeouts are exclusive
   ackNxdExclusive: assert property (@(posedge clk) disable iff (rst)
      !(busAck && setNxd));

endmodule

/* hw/nxdTimer.sv */
//////////////////////////////
// Watches only the responder addressed at cycle start
// An undecoded request leaves it idle
//////////////////////////////
`timescale 1ns/1ps

module nxdTimer
(
   input  logic clk,
   input  logic rst,
   input  logic busReq,
   input  logic ubaReq,
   input  logic ubaAck,
   input  logic devReq,
   input  logic devAck,
   output logic busAck,
   output logic setNxd
);

   ubaPkg::wdStateT state;
   ubaPkg::wdCntT   cnt;
   // Set when the CSR was addressed, clear for the device
   logic            uba;
   logic            selAck;
   logic            lastCnt;

   // Acknowledge of the remembered responder
   assign selAck  = uba ? ubaAck : devAck;
   // Final count cycle
   assign lastCnt = (cnt == ubaPkg::wdCntT'(ubaPkg::nxdTimeout - 1));

   //////////////////////////////
   // Watchdog FSM
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= ubaPkg::wdIdle;
         cnt   <= '0;
         uba   <= 1'b0;
      end
      else
      begin
         case (state)
            ubaPkg::wdIdle:
            begin
               cnt <= '0;
               if (busReq && ubaReq)
               begin
                  uba   <= 1'b1;
                  // Responder already acknowledging
                  state <= ubaAck ? ubaPkg::wdAck : ubaPkg::wdCount;
               end
               else if (busReq && devReq)
               begin
                  uba   <= 1'b0;
                  state <= devAck ? ubaPkg::wdAck : ubaPkg::wdCount;
               end
            end
            ubaPkg::wdCount:
            begin
               if (selAck)
               begin
                  state <= ubaPkg::wdAck;
               end
               else if (lastCnt)
               begin
                  // No answer within the timeout
                  state <= ubaPkg::wdNxd;
               end
               else
               begin
                  cnt <= cnt + 1'b1;
               end
            end
            ubaPkg::wdAck:
            begin
               // Grant held until the master drops its request
               if (!busReq)
               begin
                  state <= ubaPkg::wdIdle;
               end
            end
            ubaPkg::wdNxd:
            begin
               state <= ubaPkg::wdWait;
            end
            ubaPkg::wdWait:
            begin
               if (!busReq)
               begin
                  state <= ubaPkg::wdIdle;
               end
            end
            default:
            begin
               state <= ubaPkg::wdIdle;
            end
         endcase
      end
   end

   // Moore outputs
   assign busAck = (state == ubaPkg::wdAck);
   assign setNxd = (state == ubaPkg::wdNxd);

   // Timeout pulse never stretches
   nxdPulseOnce: assert property (@(posedge clk) disable iff (rst)
      setNxd |=> !setNxd);

endmodule

/* hw/ubaCsr.sv */
//////////////////////////////
// Only the NXD flag is implemented, other bits read zero
//////////////////////////////
`timescale 1ns/1ps

module ubaCsr
(
   input  logic         clk,
   input  logic         rst,
   input  logic         busReq,
   input  logic         busWrite,
   input  ubaPkg::addrT busAddr,
   input  ubaPkg::dataT busWData,
   input  logic         setNxd,
   output logic         ubaReq,
   output logic         ubaAck,
   output ubaPkg::dataT ubaRData
);

   logic         nxdFlag;
   logic         firstCycle;
   ubaPkg::dataT status;

   // Own address decode
   assign ubaReq     = busReq && (busAddr == ubaPkg::csrAddr);
   // Request seen but not yet answered
   assign firstCycle = ubaReq && !ubaAck;

   // Status word layout
   always_comb
   begin
      status                = '0;
      status[ubaPkg::nxdBit] = nxdFlag;
   end

   //////////////////////////////
   // Acknowledge and NXD flag
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ubaAck  <= 1'b0;
         nxdFlag <= 1'b0;
      end
      else
      begin
         // One cycle latency, dropped with the request
         ubaAck <= ubaReq;
         // Timeout set wins over a clearing write
         if (setNxd)
         begin
            nxdFlag <= 1'b1;
         end
         else if (firstCycle && busWrite && busWData[ubaPkg::nxdBit])
         begin
            nxdFlag <= 1'b0;
         end
      end
   end

   // Read data valid with the acknowledge
   always_ff @(posedge clk)
   begin
      if (firstCycle)
      begin
         ubaRData <= status;
      end
   end

endmodule

/* hw/devRegs.sv */
//////////////////////////////
// Claims every address but the CSR
// Holes and stray addresses never acknowledge
//////////////////////////////
`timescale 1ns/1ps

module devRegs
(
   input  logic         clk,
   input  logic         rst,
   input  logic         busReq,
   input  logic         busWrite,
   input  ubaPkg::addrT busAddr,
   input  ubaPkg::dataT busWData,
   output logic         devReq,
   output logic         devAck,
   output ubaPkg::dataT devRData
);

   ubaPkg::dataT   regs [ubaPkg::devWords];
   ubaPkg::devCntT cnt;
   ubaPkg::addrT   offset;
   ubaPkg::devIdxT idx;
   logic           hit;
   logic           ackNow;

   // Catch-all decode
   assign devReq = busReq && (busAddr != ubaPkg::csrAddr);

   // Offset inside the window
   assign offset = busAddr - ubaPkg::devBase;
   assign idx    = offset[ubaPkg::devIdxW-1:0];
   // Implemented registers only
   assign hit    = (busAddr >= ubaPkg::devBase) && (offset < ubaPkg::devWords);

   // Latency expires this cycle
   assign ackNow = devReq && hit && !devAck &&
                   (cnt == ubaPkg::devCntT'(ubaPkg::devLatency - 1));

   //////////////////////////////
   // Latency counter and registers
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         devAck <= 1'b0;
         cnt    <= '0;
         for (int i = 0; i < ubaPkg::devWords; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (!devReq)
      begin
         // Idle between cycles
         devAck <= 1'b0;
         cnt    <= '0;
      end
      else if (ackNow)
      begin
         devAck <= 1'b1;
         if (busWrite)
         begin
            regs[idx] <= busWData;
         end
      end
      else if (hit && !devAck)
      begin
         cnt <= cnt + 1'b1;
      end
   end

   // Read data loaded with the acknowledge, held afterwards
   always_ff @(posedge clk)
   begin
      if (ackNow)
      begin
         devRData <= regs[idx];
      end
   end

endmodule

/* hw/ubaSubsys.sv */
//////////////////////////////
// Host command port to a single-master Unibus slice
//////////////////////////////
`timescale 1ns/1ps

module ubaSubsys
(
   input  logic         clk,
   input  logic         rst,
   input  logic         cmdStb,
   input  logic         cmdWrite,
   input  ubaPkg::addrT cmdAddr,
   input  ubaPkg::dataT cmdData,
   output logic         rspStb,
   output ubaPkg::dataT rspData,
   output logic         rspNxd,
   output logic         busy
);

   // Shared bus
   logic         busReq;
   logic         busWrite;
   ubaPkg::addrT busAddr;
   ubaPkg::dataT busWData;
   ubaPkg::dataT busRData;
   logic         busAck;
   logic         setNxd;

   // Responder handshakes
   logic         ubaReq;
   logic         ubaAck;
   ubaPkg::dataT ubaRData;
   logic         devReq;
   logic         devAck;
   ubaPkg::dataT devRData;

   // Read data from whichever responder acknowledges
   assign busRData = ubaAck ? ubaRData : devRData;

   busMaster busMaster_i (
      .clk, .rst, .cmdStb, .cmdWrite, .cmdAddr, .cmdData,
      .rspStb, .rspData, .rspNxd, .busy,
      .busReq, .busWrite, .busAddr, .busWData, .busAck, .setNxd, .busRData
   );

   nxdTimer nxdTimer_i (
      .clk, .rst, .busReq, .ubaReq, .ubaAck, .devReq, .devAck, .busAck, .setNxd
   );

   ubaCsr ubaCsr_i (
      .clk, .rst, .busReq, .busWrite, .busAddr, .busWData, .setNxd,
      .ubaReq, .ubaAck, .ubaRData
   );

   devRegs devRegs_i (
      .clk, .rst, .busReq, .busWrite, .busAddr, .busWData,
      .devReq, .devAck, .devRData
   );

endmodule

/* verif/ubaSubsysTb.sv */
//////////////////////////////
// Directed tests only; outputs sampled on the falling edge
// Every response wait gives up after 100 cycles
//////////////////////////////
`timescale 1ns/1ps

module ubaSubsysTb;

   logic         clk;
   logic         rst;
   logic         cmdStb;
   logic         cmdWrite;
   ubaPkg::addrT cmdAddr;
   ubaPkg::dataT cmdData;
   logic         rspStb;
   ubaPkg::dataT rspData;
   logic         rspNxd;
   logic         busy;

   int           errors;
   int           checks;
   logic [31:0]  seed;
   // Expected contents of the device registers
   ubaPkg::dataT model [ubaPkg::devWords];

   ubaSubsys ubaSubsys_i (
      .clk, .rst, .cmdStb, .cmdWrite, .cmdAddr, .cmdData,
      .rspStb, .rspData, .rspNxd, .busy
   );

   // 40 ns period
   always #20 clk = ~clk;

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Xorshift32 step
   function automatic logic [31:0] nextRand();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   // Word address inside the device window
   function automatic ubaPkg::addrT devAddr(input int offset);
      return ubaPkg::addrT'(ubaPkg::devBase + ubaPkg::addrT'(offset));
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   // One strobe, then wait for the response
   task automatic runCommand(input logic wr, input ubaPkg::addrT addr,
                             input ubaPkg::dataT data,
                             output ubaPkg::dataT rd, output logic nxd);
      int n;
      n = 0;
      @(posedge clk);
      cmdStb   <= 1'b1;
      cmdWrite <= wr;
      cmdAddr  <= addr;
      cmdData  <= data;
      @(posedge clk);
      cmdStb <= 1'b0;
      @(negedge clk);
      while (!rspStb && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      rd  = rspData;
      nxd = rspNxd;
      if (!rspStb)
      begin
         $display("No response within 100 cycles for the command at address 0x%h", addr);
         errors++;
      end
   endtask

   task automatic writeCheck(input ubaPkg::addrT addr, input ubaPkg::dataT data,
                             input logic expNxd);
      ubaPkg::dataT rd;
      logic         nxd;
      runCommand(1'b1, addr, data, rd, nxd);
      compare($sformatf("rspNxd@%h", addr), 32'(nxd), 32'(expNxd));
   endtask

   task automatic readCheck(input ubaPkg::addrT addr, input ubaPkg::dataT expData,
                            input logic expNxd);
      ubaPkg::dataT rd;
      logic         nxd;
      runCommand(1'b0, addr, '0, rd, nxd);
      compare($sformatf("rspNxd@%h", addr), 32'(nxd), 32'(expNxd));
      // Data only meaningful on a real acknowledge
      if (!expNxd)
      begin
         compare($sformatf("rspData@%h", addr), 32'(rd), 32'(expData));
      end
   endtask

   task automatic reportTest(input string name, input int start);
      $display("%s finished with %0d errors", name, errors - start);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic devReadBack();
      int           start;
      logic [31:0]  r;
      ubaPkg::dataT val;
      start = errors;
      // Fresh registers after reset
      for (int i = 0; i < ubaPkg::devWords; i++)
      begin
         readCheck(devAddr(i), '0, 1'b0);
      end
      // Top bits hold the index so values differ
      for (int i = 0; i < ubaPkg::devWords; i++)
      begin
         r   = nextRand();
         val = {i[1:0], r[13:0]};
         writeCheck(devAddr(i), val, 1'b0);
         model[i] = val;
      end
      for (int i = 0; i < ubaPkg::devWords; i++)
      begin
         readCheck(devAddr(i), model[i], 1'b0);
      end
      reportTest("devReadBack", start);
   endtask

   task automatic stickyFlag();
      int           start;
      ubaPkg::dataT flagSet;
      start   = errors;
      flagSet = ubaPkg::dataT'(1) << ubaPkg::nxdBit;
      // Clear before any timeout
      readCheck(ubaPkg::csrAddr, '0, 1'b0);
      readCheck(devAddr(4), '0, 1'b1);
      readCheck(ubaPkg::csrAddr, flagSet, 1'b0);
      // Write one to clear
      writeCheck(ubaPkg::csrAddr, flagSet, 1'b0);
      readCheck(ubaPkg::csrAddr, '0, 1'b0);
      reportTest("stickyFlag", start);
   endtask

   task automatic nxdAccess();
      int          start;
      logic [31:0] r;
      start = errors;
      // Unimplemented holes of the device window
      for (int i = ubaPkg::devWords; i < 8; i++)
      begin
         r = nextRand();
         readCheck(devAddr(i), '0, 1'b1);
         writeCheck(devAddr(i), r[15:0], 1'b1);
      end
      // Outside both windows
      readCheck(18'o100000, '0, 1'b1);
      writeCheck(18'o100000, 16'hdead, 1'b1);
      // Registers untouched
      for (int i = 0; i < ubaPkg::devWords; i++)
      begin
         readCheck(devAddr(i), model[i], 1'b0);
      end
      reportTest("nxdAccess", start);
   endtask

   task automatic droppedCommand();
      int           start;
      int           n;
      int           extra;
      logic [31:0]  r;
      ubaPkg::dataT first;
      start = errors;
      n     = 0;
      extra = 0;
      r     = nextRand();
      first = r[15:0];
      @(posedge clk);
      cmdStb   <= 1'b1;
      cmdWrite <= 1'b1;
      cmdAddr  <= devAddr(0);
      cmdData  <= first;
      @(posedge clk);
      cmdStb <= 1'b0;
      @(negedge clk);
      compare("busy", 32'(busy), 32'd1);
      // Second strobe lands inside the busy window
      @(posedge clk);
      cmdStb  <= 1'b1;
      cmdAddr <= devAddr(1);
      cmdData <= ~first;
      @(posedge clk);
      cmdStb <= 1'b0;
      @(negedge clk);
      while (!rspStb && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (!rspStb)
      begin
         $display("No response within 100 cycles for the first of two commands");
         errors++;
      end
      compare("rspNxd", 32'(rspNxd), 32'd0);
      // Busy drops together with the response strobe
      compare("busy", 32'(busy), 32'd0);
      model[0] = first;
      // Count stray responses
      repeat (100)
      begin
         @(negedge clk);
         if (rspStb)
         begin
            extra++;
         end
      end
      compare("rspStb count", 32'(extra), 32'd0);
      readCheck(devAddr(0), model[0], 1'b0);
      readCheck(devAddr(1), model[1], 1'b0);
      reportTest("droppedCommand", start);
   endtask

   task automatic randomTraffic();
      int          start;
      int          idx;
      logic [31:0] r;
      start = errors;
      for (int k = 0; k < 40; k++)
      begin
         r   = nextRand();
         idx = int'(r[2:1]);
         if (r[0])
         begin
            writeCheck(devAddr(idx), r[31:16], 1'b0);
            model[idx] = r[31:16];
         end
         else
         begin
            readCheck(devAddr(idx), model[idx], 1'b0);
         end
      end
      reportTest("randomTraffic", start);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      clk      = 1'b0;
      rst      = 1'b1;
      cmdStb   = 1'b0;
      cmdWrite = 1'b0;
      cmdAddr  = '0;
      cmdData  = '0;
      errors   = 0;
      checks   = 0;
      seed     = 32'h1906;
      for (int i = 0; i < ubaPkg::devWords; i++)
      begin
         model[i] = '0;
      end
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      devReadBack();
      // Must run before any other timeout
      stickyFlag();
      nxdAccess();
      droppedCommand();
      randomTraffic();
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Test OK");
      end
      else
      begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
hw/ubaPkg.sv
hw/busMaster.sv
hw/nxdTimer.sv
hw/ubaCsr.sv
hw/devRegs.sv
hw/ubaSubsys.sv
verif/ubaSubsysTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ubaSubsysTb &&
out=$(./obj_dir/VubaSubsysTb) &&
echo "$out" &&
echo "$out" | grep -qx "Test OK" ||
{ echo "Simulation did not pass"; exit 1; }
